//--- hdl/fpuPkg.sv
package fpuPkg;

  localparam int addrWidth = 5;
  localparam int dataWidth = 32;

  // register byte offsets
  localparam logic [addrWidth-1:0] regX      = 5'h00;
  localparam logic [addrWidth-1:0] regY      = 5'h04;
  localparam logic [addrWidth-1:0] regCtrl   = 5'h08;
  localparam logic [addrWidth-1:0] regStatus = 5'h0C;
  localparam logic [addrWidth-1:0] regResult = 5'h10;

  typedef enum logic [1:0] {
    opAdd = 2'd0,
    opSub = 2'd1,
    opMul = 2'd2,
    opDiv = 2'd3
  } fpOpT;

  // command word layout
  localparam int ctrlOpLsb = 0;
  localparam int ctrlFlt   = 2;
  localparam int ctrlFloor = 3;
  localparam int ctrlWidth = 4;

  // 2^23 as a float, puts integers at the mantissa LSB
  localparam logic [dataWidth-1:0] convY = 32'h4B00_0000;

  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

endpackage

//--- hdl/fpAdder.sv
`timescale 1ns/1ps

module fpAdder (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          run,
  input  logic                          u,      // FLT
  input  logic                          v,      // FLOOR
  input  logic [fpuPkg::dataWidth-1:0]  x,
  input  logic [fpuPkg::dataWidth-1:0]  y,
  output logic                          stall,
  output logic [fpuPkg::dataWidth-1:0]  z
);

  logic [1:0]  state;
  logic        xs, ys;
  logic        xn, yn;  // zero operands
  logic [7:0]  xe, ye;
  logic [24:0] xm, ym;
  logic [8:0]  dx, dy;
  logic [7:0]  e0;
  logic [7:0]  shX, shY;
  logic [24:0] x3, y3;
  logic [26:0] sum;
  logic [26:0] s;
  logic        above;
  logic [4:0]  sc;
  logic [24:0] t3;
  logic [8:0]  e1;

  // arithmetic right shift in steps of 1, 4 and 16
  function automatic logic [24:0] alignRight(input logic sgn, input logic [24:0] m,
                                            input logic [7:0] sh);
    logic signed [25:0] a;
    a = {sgn, m};
    a = a >>> sh[1:0];
    a = a >>> {sh[3:2], 2'b00};
    a = a >>> {sh[4], 4'b0000};
    return (sh[7:5] != 3'b000) ? {25{sgn}} : a[24:0];
  endfunction

  assign xs = x[31];
  assign ys = y[31];
  assign xe = u ? 8'h96 : x[30:23];  // integer sits at exponent 150
  assign ye = y[30:23];
  assign xm = {~u | x[23], x[22:0], 1'b0};
  assign ym = {~u & ~v, y[22:0], 1'b0};
  assign xn = (x[30:0] == '0);
  assign yn = (y[30:0] == '0);

  assign dx  = {1'b0, xe} - {1'b0, ye};
  assign dy  = {1'b0, ye} - {1'b0, xe};
  assign e0  = dx[8] ? ye : xe;  // larger exponent wins
  assign shX = dy[8] ? 8'd0 : dy[7:0];
  assign shY = dx[8] ? 8'd0 : dx[7:0];

  always_ff @(posedge clk) begin
    x3  <= alignRight(xs, (xs & ~u) ? -xm : xm, shX);
    y3  <= alignRight(ys, (ys & ~u) ? -ym : ym, shY);
    sum <= {xs, xs, x3} + {ys, ys, y3};
    t3  <= s[25:1] << sc;
  end

  assign s = sum[26] ? -sum : sum;  // magnitude

  // leading one, two bits per step from the top
  always_comb begin
    above = 1'b1;
    sc    = 5'd24;
    for (int k = 0; k < 12; k++) begin
      if (above && s[25-2*k]) begin
        sc = 5'(2*k);
      end else if (above && s[24-2*k]) begin
        sc = 5'(2*k + 1);
      end
      above = above & ~s[25-2*k] & ~s[24-2*k];
    end
  end

  assign e1 = {1'b0, e0} - {4'd0, sc} + 9'd1;

  always_comb begin
    if (v) begin
      z = {{7{sum[26]}}, sum[25:1]};  // floor as integer
    end else if (xn) begin
      z = (u | yn) ? '0 : y;
    end else if (yn) begin
      z = x;
    end else if (t3 == '0 || e1[8]) begin
      z = '0;  // cancelled or underflow
    end else begin
      z = {sum[26], e1[7:0], t3[23:1]};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= 2'd0;
    end else begin
      state <= run ? state + 2'd1 : 2'd0;
    end
  end

  assign stall = run & (state != 2'd3);

  // requester drops run after the result so state never wraps
  assert property (@(posedge clk) disable iff (!arstN)
    run && !stall |=> !run);

endmodule

//--- hdl/fpMultiplier.sv
`timescale 1ns/1ps

module fpMultiplier (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          run,
  input  logic [fpuPkg::dataWidth-1:0]  x,
  input  logic [fpuPkg::dataWidth-1:0]  y,
  output logic                          stall,
  output logic [fpuPkg::dataWidth-1:0]  z
);

  logic [4:0]  cnt;
  logic [47:0] prod;     // accumulator high, multiplier low
  logic [24:0] partial;
  logic [9:0]  eSum, eOut;
  logic        zeroOut;

  assign partial = {1'b0, prod[47:24]} + (prod[0] ? {2'b01, x[22:0]} : 25'd0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cnt <= 5'd0;
    end else begin
      cnt <= run ? cnt + 5'd1 : 5'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      if (cnt == 5'd0) begin
        prod <= {24'd0, 1'b1, y[22:0]};
      end else if (cnt <= 5'd24) begin
        prod <= {partial, prod[23:1]};  // shift-add step
      end
    end
  end

  assign stall = run & (cnt != 5'd25);

  assign eSum = {2'b00, x[30:23]} + {2'b00, y[30:23]} - 10'd127;
  assign eOut = eSum + {9'd0, prod[47]};

  assign zeroOut = (x[30:23] == 8'd0) || (y[30:23] == 8'd0) ||
                   eOut[9] || (eOut == 10'd0) || (eOut[8:0] >= 9'd255);

  assign z = zeroOut ? '0 :
             {x[31] ^ y[31], eOut[7:0], prod[47] ? prod[46:24] : prod[45:23]};

  // requester drops run once stall falls
  assert property (@(posedge clk) disable iff (!arstN) run |-> cnt <= 5'd25);

endmodule

//--- hdl/fpDivider.sv
`timescale 1ns/1ps

module fpDivider (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          run,
  input  logic [fpuPkg::dataWidth-1:0]  x,
  input  logic [fpuPkg::dataWidth-1:0]  y,
  output logic                          stall,
  output logic [fpuPkg::dataWidth-1:0]  z
);

  logic [4:0]  cnt;
  logic [24:0] rem;
  logic [24:0] quot;
  logic [25:0] diff;
  logic [9:0]  eDiff, eOut;
  logic        zeroOut;

  assign diff = {1'b0, rem} - {3'b001, y[22:0]};  // diff[25] set means no subtract

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cnt <= 5'd0;
    end else begin
      cnt <= run ? cnt + 5'd1 : 5'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      if (cnt == 5'd0) begin
        rem  <= {2'b01, x[22:0]};
        quot <= '0;
      end else if (cnt <= 5'd25) begin
        rem  <= diff[25] ? {rem[23:0], 1'b0} : {diff[23:0], 1'b0};
        quot <= {quot[23:0], ~diff[25]};
      end
    end
  end

  assign stall = run & (cnt != 5'd26);

  assign eDiff = {2'b00, x[30:23]} - {2'b00, y[30:23]} + 10'd127;
  assign eOut  = eDiff - {9'd0, ~quot[24]};  // quotient below one

  // divide by zero also lands here
  assign zeroOut = (x[30:23] == 8'd0) || (y[30:23] == 8'd0) ||
                   eOut[9] || (eOut == 10'd0) || (eOut[8:0] >= 9'd255);

  assign z = zeroOut ? '0 :
             {x[31] ^ y[31], eOut[7:0], quot[24] ? quot[23:1] : quot[22:0]};

  assert property (@(posedge clk) disable iff (!arstN) run |-> cnt <= 5'd26);

endmodule

//--- hdl/fpuRegs.sv
`timescale 1ns/1ps

module fpuRegs (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [fpuPkg::addrWidth-1:0]  awAddr,
  input  logic                          awValid,
  output logic                          awReady,
  input  logic [fpuPkg::dataWidth-1:0]  wData,
  input  logic                          wValid,
  output logic                          wReady,
  output logic [1:0]                    bResp,
  output logic                          bValid,
  input  logic                          bReady,
  input  logic [fpuPkg::addrWidth-1:0]  arAddr,
  input  logic                          arValid,
  output logic                          arReady,
  output logic [fpuPkg::dataWidth-1:0]  rData,
  output logic [1:0]                    rResp,
  output logic                          rValid,
  input  logic                          rReady,
  output logic                          addRun,
  output logic                          mulRun,
  output logic                          divRun,
  output logic [fpuPkg::dataWidth-1:0]  opX,
  output logic [fpuPkg::dataWidth-1:0]  opY,
  output logic                          fltMode,
  output logic                          floorMode,
  input  logic                          addStall,
  input  logic                          mulStall,
  input  logic                          divStall,
  input  logic [fpuPkg::dataWidth-1:0]  addZ,
  input  logic [fpuPkg::dataWidth-1:0]  mulZ,
  input  logic [fpuPkg::dataWidth-1:0]  divZ
);
  import fpuPkg::*;

  logic [dataWidth-1:0] xReg, yReg, resultReg, unitZ;
  logic [ctrlWidth-1:0] cmdReg;
  fpOpT                 cmdOp, newOp;
  logic                 busy;
  logic                 wrOffer, wrFire, wrMapped;
  logic                 arOffer, rdFire;
  logic                 done;

  assign wrOffer  = ~awReady & awValid & wValid & ~bValid & ~busy;
  assign wrFire   = awReady & awValid & wValid;
  assign wrMapped = (awAddr == regX) || (awAddr == regY) || (awAddr == regCtrl);
  assign arOffer  = ~arReady & arValid & ~rValid & ~(busy & (arAddr == regResult));
  assign rdFire   = arReady & arValid;

  assign newOp = fpOpT'(wData[ctrlOpLsb +: 2]);
  assign cmdOp = fpOpT'(cmdReg[ctrlOpLsb +: 2]);

  assign done  = (addRun & ~addStall) | (mulRun & ~mulStall) | (divRun & ~divStall);
  assign unitZ = addRun ? addZ : (mulRun ? mulZ : divZ);

  assign fltMode   = (cmdOp == opAdd) & cmdReg[ctrlFlt];
  assign floorMode = (cmdOp == opAdd) & cmdReg[ctrlFloor];
  assign opX = xReg;
  assign opY = (fltMode | floorMode) ? convY :
               (cmdOp == opSub) ? {~yReg[31], yReg[30:0]} : yReg;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      awReady <= 1'b0;
      wReady  <= 1'b0;
      bValid  <= 1'b0;
      arReady <= 1'b0;
      rValid  <= 1'b0;
    end else begin
      awReady <= wrOffer;  // both ready for one cycle
      wReady  <= wrOffer;
      arReady <= arOffer;
      if (wrFire) begin
        bValid <= 1'b1;
      end else if (bReady) begin
        bValid <= 1'b0;
      end
      if (rdFire) begin
        rValid <= 1'b1;
      end else if (rReady) begin
        rValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrFire) begin
      bResp <= wrMapped ? respOkay : respSlvErr;
      if (awAddr == regX) begin
        xReg <= wData;
      end
      if (awAddr == regY) begin
        yReg <= wData;
      end
    end
    if (rdFire) begin
      rResp <= respOkay;
      case (arAddr)
        regX:      rData <= xReg;
        regY:      rData <= yReg;
        regCtrl:   rData <= {{(dataWidth-ctrlWidth){1'b0}}, cmdReg};
        regStatus: rData <= {{(dataWidth-1){1'b0}}, busy};
        regResult: rData <= resultReg;
        default: begin
          rData <= '0;
          rResp <= respSlvErr;
        end
      endcase
    end
  end

  // command start and result capture
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cmdReg    <= '0;
      busy      <= 1'b0;
      addRun    <= 1'b0;
      mulRun    <= 1'b0;
      divRun    <= 1'b0;
      resultReg <= '0;
    end else if (wrFire && awAddr == regCtrl) begin
      cmdReg <= wData[ctrlWidth-1:0];
      busy   <= 1'b1;
      addRun <= (newOp == opAdd) || (newOp == opSub);
      mulRun <= newOp == opMul;
      divRun <= newOp == opDiv;
    end else if (done) begin
      resultReg <= unitZ;
      busy      <= 1'b0;
      addRun    <= 1'b0;
      mulRun    <= 1'b0;
      divRun    <= 1'b0;
    end
  end

  // no write lands while a command runs
  assert property (@(posedge clk) disable iff (!arstN) wrFire |-> !busy);

endmodule

//--- hdl/fpuTop.sv
`timescale 1ns/1ps

module fpuTop (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [fpuPkg::addrWidth-1:0]  awAddr,
  input  logic                          awValid,
  output logic                          awReady,
  input  logic [fpuPkg::dataWidth-1:0]  wData,
  input  logic                          wValid,
  output logic                          wReady,
  output logic [1:0]                    bResp,
  output logic                          bValid,
  input  logic                          bReady,
  input  logic [fpuPkg::addrWidth-1:0]  arAddr,
  input  logic                          arValid,
  output logic                          arReady,
  output logic [fpuPkg::dataWidth-1:0]  rData,
  output logic [1:0]                    rResp,
  output logic                          rValid,
  input  logic                          rReady
);
  import fpuPkg::*;

  logic                 addRun, mulRun, divRun;
  logic                 addStall, mulStall, divStall;
  logic                 fltMode, floorMode;
  logic [dataWidth-1:0] opX, opY;
  logic [dataWidth-1:0] addZ, mulZ, divZ;

  fpuRegs regs (
    .clk(clk), .arstN(arstN),
    .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wValid(wValid), .wReady(wReady),
    .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
    .addRun(addRun), .mulRun(mulRun), .divRun(divRun),
    .opX(opX), .opY(opY), .fltMode(fltMode), .floorMode(floorMode),
    .addStall(addStall), .mulStall(mulStall), .divStall(divStall),
    .addZ(addZ), .mulZ(mulZ), .divZ(divZ)
  );

  fpAdder adder (
    .clk(clk), .arstN(arstN), .run(addRun), .u(fltMode), .v(floorMode),
    .x(opX), .y(opY), .stall(addStall), .z(addZ)
  );

  fpMultiplier multiplier (
    .clk(clk), .arstN(arstN), .run(mulRun),
    .x(opX), .y(opY), .stall(mulStall), .z(mulZ)
  );

  fpDivider divider (
    .clk(clk), .arstN(arstN), .run(divRun),
    .x(opX), .y(opY), .stall(divStall), .z(divZ)
  );

endmodule

//--- verification/fpuTb.sv
`timescale 1ns/1ps

module fpuTb;
  import fpuPkg::*;

  localparam int cycleLimit = 4000;  // about 60 ops at 30 cycles plus bus overhead

  logic                 clk, arstN;
  logic [addrWidth-1:0] awAddr, arAddr;
  logic                 awValid, awReady, wValid, wReady, bValid, bReady;
  logic                 arValid, arReady, rValid, rReady;
  logic [dataWidth-1:0] wData, rData;
  logic [1:0]           bResp, rResp;
  logic [31:0]          rngState;
  int                   cycles = 0;

  fpuTop DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", cycleLimit);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] t;
    t = s ^ (s << 13);
    t = t ^ (t >> 17);
    return t ^ (t << 5);
  endfunction

  // repack an exactly representable double as a single
  function automatic logic [31:0] realToSingle(input real r);
    logic [63:0] d;
    d = $realtobits(r);
    if (d[62:0] == '0) begin
      return 32'd0;
    end
    return {d[63], 8'(d[62:52] - 11'd896), d[51:29]};
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
    if (got !== expected) begin
      $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, expected);
      $display("Simulation failed");
      $fatal(1, "first mismatch");
    end
  endtask

  task automatic axiWrite(input logic [addrWidth-1:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge clk);
    awAddr  = addr;
    wData   = data;
    awValid = 1'b1;
    wValid  = 1'b1;
    @(negedge clk);
    while (!awReady) @(negedge clk);  // held off while busy
    @(negedge clk);
    awValid = 1'b0;
    wValid  = 1'b0;
    while (!bValid) @(negedge clk);
    resp   = bResp;
    bReady = 1'b1;
    @(negedge clk);
    bReady = 1'b0;
  endtask

  task automatic axiRead(input logic [addrWidth-1:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    @(negedge clk);
    arAddr  = addr;
    arValid = 1'b1;
    @(negedge clk);
    while (!arReady) @(negedge clk);
    @(negedge clk);
    arValid = 1'b0;
    while (!rValid) @(negedge clk);
    data   = rData;
    resp   = rResp;
    rReady = 1'b1;
    @(negedge clk);
    rReady = 1'b0;
  endtask

  task automatic runOp(input logic [31:0] x, input logic [31:0] y, input logic [31:0] cmd,
                       output logic [31:0] result);
    logic [1:0] resp;
    axiWrite(regX, x, resp);
    check(32'(resp), 32'(respOkay), "write response for X");
    axiWrite(regY, y, resp);
    check(32'(resp), 32'(respOkay), "write response for Y");
    axiWrite(regCtrl, cmd, resp);
    check(32'(resp), 32'(respOkay), "write response for command");
    axiRead(regResult, result, resp);  // returns once the command is done
    check(32'(resp), 32'(respOkay), "read response for result");
  endtask

  task automatic runArith(input real a, input real b, input fpOpT op);
    real         expected;
    logic [31:0] result;
    case (op)
      opAdd:   expected = a + b;
      opSub:   expected = a - b;
      opMul:   expected = a * b;
      default: expected = (b == 0.0) ? 0.0 : a / b;  // zero divisor gives zero
    endcase
    runOp(realToSingle(a), realToSingle(b), 32'(op), result);
    check(result, realToSingle(expected), $sformatf("%s of %f and %f", op.name(), a, b));
  endtask

  task automatic runFloor(input real r);
    logic [31:0] result;
    runOp(realToSingle(r), 32'd0, 32'(opAdd) | (32'd1 << ctrlFloor), result);
    check(result, int'($floor(r)), $sformatf("FLOOR of %f", r));
  endtask

  task automatic testAddSub();
    runArith(1.5, 2.25, opAdd);
    runArith(-1.5, 2.25, opAdd);
    runArith(1.5, 2.25, opSub);
    runArith(-3.0, -0.5, opAdd);
    runArith(100.0, -0.125, opAdd);
    runArith(2.25, 2.25, opSub);  // cancels to zero
    runArith(0.0, 5.5, opAdd);
    runArith(0.0, 5.5, opSub);
    runArith(7.0, 0.0, opSub);
  endtask

  task automatic testMultiply();
    real a, b;
    runArith(-3.0, -4.0, opMul);
    runArith(0.0, 3.0, opMul);
    for (int i = 0; i < 10; i++) begin
      rngState = xorshift(rngState);
      a = real'(int'(rngState[7:0]) + 1) * real'(1 << rngState[10:8]) / 16.0;
      b = real'(int'(rngState[17:12]) + 1);
      if (rngState[20]) begin
        a = -a;
      end
      if (rngState[21]) begin
        b = -b;
      end
      runArith(a, b, opMul);
    end
  endtask

  task automatic testDivide();
    real a, b;
    runArith(6.0, 1.5, opDiv);
    runArith(-7.5, 2.5, opDiv);
    runArith(4.5, 1.5, opDiv);  // mantissa quotient below one
    runArith(1.0, 4.0, opDiv);
    runArith(3.0, 0.0, opDiv);
    for (int i = 0; i < 6; i++) begin
      rngState = xorshift(rngState);
      b = real'((int'(rngState[13:8]) + 1) << rngState[18:16]) / 8.0;
      a = real'(int'(rngState[6:0]) + 1) * b;  // exact quotient
      if (rngState[24]) begin
        a = -a;
      end
      runArith(a, b, opDiv);
    end
  endtask

  task automatic testConvert();
    logic [31:0] result;
    int          n;
    for (int i = 0; i < 8; i++) begin
      rngState = xorshift(rngState);
      n = int'(rngState & 32'h007F_FFFF);
      runOp(n, 32'd0, 32'(opAdd) | (32'd1 << ctrlFlt), result);
      check(result, realToSingle(real'(n)), $sformatf("FLT of %0d", n));
    end
    runFloor(7.75);
    runFloor(-2.5);
    runFloor(0.5);
  endtask

  task automatic testBusRules();
    logic [31:0] data;
    logic [1:0]  resp;
    int          startCycle;
    axiWrite(regX, realToSingle(12.0), resp);
    axiWrite(regY, realToSingle(-0.5), resp);
    axiWrite(regCtrl, 32'(opMul), resp);
    axiRead(regStatus, data, resp);
    check(32'(data[0]), 32'd1, "busy right after command");
    check(32'(resp), 32'(respOkay), "status read response");
    axiRead(regResult, data, resp);
    check(data, realToSingle(-6.0), "result read straight after command");
    axiWrite(regResult, 32'h1234_5678, resp);
    check(32'(resp), 32'(respSlvErr), "write to result register");
    axiRead(5'h14, data, resp);
    check(32'(resp), 32'(respSlvErr), "read of unmapped offset");
    axiWrite(regX, realToSingle(9.0), resp);
    axiWrite(regY, realToSingle(3.0), resp);
    axiWrite(regCtrl, 32'(opDiv), resp);
    startCycle = cycles;
    axiWrite(regCtrl, 32'(opSub), resp);  // waits for the divide
    check(32'(cycles - startCycle >= 25), 32'd1, "second command held off");
    axiRead(regResult, data, resp);
    check(data, realToSingle(6.0), "result of second command");
  endtask

  initial begin
    arstN    = 1'b0;
    awAddr   = '0;
    awValid  = 1'b0;
    wData    = '0;
    wValid   = 1'b0;
    bReady   = 1'b0;
    arAddr   = '0;
    arValid  = 1'b0;
    rReady   = 1'b0;
    rngState = 32'h2273;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    testAddSub();
    testMultiply();
    testDivide();
    testConvert();
    testBusRules();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- files.f
hdl/fpuPkg.sv
hdl/fpAdder.sv
hdl/fpMultiplier.sv
hdl/fpDivider.sv
hdl/fpuRegs.sv
hdl/fpuTop.sv
verification/fpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fpuTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
